// File: hdl/fpFormatPkg.sv
`default_nettype none

package fpFormatPkg;

	// IEEE-754 double layout.
	localparam int FP_W   = 64;
	localparam int EXP_W  = 11;
	localparam int FRAC_W = 52;

	// Significand with the hidden bit restored, also the adder width.
	localparam int SIG_W  = FRAC_W + 1;

	localparam logic [EXP_W-1:0] EXP_MAX = EXP_W'(2047); // NaN/Inf on input, overflow on output.

	// One operand after decode. Denormals are already flushed to zero here.
	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exponent;
		logic [SIG_W-1:0] significand;
	} fpOperand;

endpackage

`default_nettype wire

// File: hdl/fpStatusPkg.sv
`default_nettype none

package fpStatusPkg;

	// Exception flags that travel with each operation.
	typedef struct packed {
		logic overflow;    // Result rounded to infinity.
		logic unsupported; // Mixed signs, NaN or infinity on input.
	} fpFlags;

	localparam fpFlags FLAGS_CLEAR = '{overflow: 1'b0, unsupported: 1'b0};

endpackage

`default_nettype wire

// File: hdl/alignBusIf.sv
`timescale 1ns/100ps
`default_nettype none

// Decode to execute. Everything here is registered in operandDecode.
interface alignBusIf;

	logic                                 valid;
	logic                                 sign;
	logic [fpFormatPkg::EXP_W-1:0]        exponent; // Larger of the two exponents.
	logic [fpFormatPkg::SIG_W-1:0]        bigSig;
	logic [fpFormatPkg::SIG_W-1:0]        smallSig;
	logic [fpFormatPkg::EXP_W-1:0]        shift;    // Exponent difference.
	fpStatusPkg::fpFlags                  flags;

	modport decodeSide (
		output valid, sign, exponent, bigSig, smallSig, shift, flags
	);

	modport executeSide (
		input valid, sign, exponent, bigSig, smallSig, shift, flags
	);

endinterface

`default_nettype wire

// File: hdl/sumBusIf.sv
`timescale 1ns/100ps
`default_nettype none

// Execute to result. The sum keeps the adder carry as its top bit.
interface sumBusIf;

	logic                          valid;
	logic                          sign;
	logic [fpFormatPkg::EXP_W-1:0] exponent;
	logic [fpFormatPkg::SIG_W:0]   sum;
	fpStatusPkg::fpFlags           flags;

	modport executeSide (
		output valid, sign, exponent, sum, flags
	);

	modport resultSide (
		input valid, sign, exponent, sum, flags
	);

endinterface

`default_nettype wire

// File: hdl/rippleCarryAdder.sv
`timescale 1ns/100ps
`default_nettype none

// Unsigned ripple-carry adder, carry out lands in the top sum bit.
module rippleCarryAdder #(
	parameter int WIDTH = 52
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic [WIDTH:0]   sum
);

	logic [WIDTH-1:0] carry;

	genvar i;
	generate
		for (i = 0; i < WIDTH; i++) begin : gBit
			if (i == 0) begin : gHalf
				// No carry in at the bottom.
				assign sum[i]   = a[i] ^ b[i];
				assign carry[i] = a[i] & b[i];
			end else begin : gFull
				assign sum[i]   = a[i] ^ b[i] ^ carry[i-1];
				assign carry[i] = (a[i] & b[i]) | (carry[i-1] & (a[i] ^ b[i]));
			end
		end
	endgenerate

	assign sum[WIDTH] = carry[WIDTH-1];

endmodule

`default_nettype wire

// File: hdl/operandDecode.sv
`timescale 1ns/100ps
`default_nettype none

module operandDecode (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         inValid,
	input  logic [fpFormatPkg::FP_W-1:0] opA,
	input  logic [fpFormatPkg::FP_W-1:0] opB,
	alignBusIf.decodeSide                align
);

	import fpFormatPkg::*;
	import fpStatusPkg::*;

	fpOperand unpackA;
	fpOperand unpackB;
	fpOperand hiOp;
	fpOperand loOp;
	fpFlags   nextFlags;

	// Hidden bit only for normal numbers, so denormals come out as zero.
	function automatic fpOperand unpack(input logic [FP_W-1:0] op);
		fpOperand u;
		u.sign     = op[FP_W-1];
		u.exponent = op[FP_W-2 -: EXP_W];
		if (u.exponent != '0)
			u.significand = {1'b1, op[FRAC_W-1:0]};
		else
			u.significand = '0;
		return u;
	endfunction

	always_comb begin
		unpackA = unpack(opA);
		unpackB = unpack(opB);

		if (unpackA.exponent >= unpackB.exponent) begin
			hiOp = unpackA;
			loOp = unpackB;
		end else begin
			hiOp = unpackB;
			loOp = unpackA;
		end

		nextFlags = FLAGS_CLEAR;
		nextFlags.unsupported = inValid &&
			((unpackA.sign != unpackB.sign) ||
			 (unpackA.exponent == EXP_MAX) ||
			 (unpackB.exponent == EXP_MAX));
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			align.valid <= 1'b0;
			align.flags <= FLAGS_CLEAR;
		end else begin
			align.valid <= inValid;
			align.flags <= nextFlags;
		end
	end

	always_ff @(posedge clk) begin
		align.sign     <= unpackA.sign; // Signs match when supported.
		align.exponent <= hiOp.exponent;
		align.bigSig   <= hiOp.significand;
		align.smallSig <= loOp.significand;
		align.shift    <= hiOp.exponent - loOp.exponent;
	end

endmodule

`default_nettype wire

// File: hdl/alignExecute.sv
`timescale 1ns/100ps
`default_nettype none

module alignExecute (
	input  logic           clk,
	input  logic           rstN,
	alignBusIf.executeSide align,
	sumBusIf.executeSide   sum
);

	import fpFormatPkg::*;
	import fpStatusPkg::*;

	logic [SIG_W-1:0] alignedSig;
	logic [SIG_W:0]   rawSum;

	// Truncating right shift.
	always_comb begin
		if (align.shift >= EXP_W'(SIG_W))
			alignedSig = '0; // Everything shifted out.
		else
			alignedSig = align.smallSig >> align.shift;
	end

	rippleCarryAdder #(
		.WIDTH (SIG_W)
	) adder (
		.a   (align.bigSig),
		.b   (alignedSig),
		.sum (rawSum)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sum.valid <= 1'b0;
			sum.flags <= FLAGS_CLEAR;
		end else begin
			sum.valid <= align.valid;
			sum.flags <= align.flags;
		end
	end

	always_ff @(posedge clk) begin
		sum.sign     <= align.sign;
		sum.exponent <= align.exponent;
		sum.sum      <= rawSum;
	end

endmodule

`default_nettype wire

// File: hdl/resultPack.sv
`timescale 1ns/100ps
`default_nettype none

module resultPack (
	input  logic                         clk,
	input  logic                         rstN,
	sumBusIf.resultSide                  sum,
	output logic                         outValid,
	output logic [fpFormatPkg::FP_W-1:0] result,
	output fpStatusPkg::fpFlags          flags
);

	import fpFormatPkg::*;
	import fpStatusPkg::*;

	logic [SIG_W-1:0] normSig;
	logic [EXP_W-1:0] normExp;
	logic [FP_W-1:0]  nextResult;
	fpFlags           nextFlags;

	always_comb begin
		// A carry out means one place right and one up in exponent.
		if (sum.sum[SIG_W]) begin
			normSig = sum.sum[SIG_W:1];
			normExp = sum.exponent + 1'b1;
		end else begin
			normSig = sum.sum[SIG_W-1:0];
			normExp = sum.exponent;
		end

		nextFlags = sum.flags;
		nextFlags.overflow = 1'b0;

		if (sum.flags.unsupported) begin
			nextResult = {sum.sign, {(FP_W-1){1'b0}}};
		end else if (sum.sum == '0) begin
			nextResult = {sum.sign, {(FP_W-1){1'b0}}}; // Signed zero.
		end else if (normExp == EXP_MAX) begin
			nextResult = {sum.sign, EXP_MAX, {FRAC_W{1'b0}}};
			nextFlags.overflow = 1'b1;
		end else begin
			nextResult = {sum.sign, normExp, normSig[FRAC_W-1:0]}; // Hidden bit dropped.
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
			flags    <= FLAGS_CLEAR;
		end else begin
			outValid <= sum.valid;
			flags    <= nextFlags;
		end
	end

	always_ff @(posedge clk) begin
		result <= nextResult;
	end

endmodule

`default_nettype wire

// File: hdl/fpAddTop.sv
`timescale 1ns/100ps
`default_nettype none

// Three-stage double adder: decode, align and add, normalize and pack.
module fpAddTop (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         inValid,
	input  logic [fpFormatPkg::FP_W-1:0] opA,
	input  logic [fpFormatPkg::FP_W-1:0] opB,
	output logic                         outValid,
	output logic [fpFormatPkg::FP_W-1:0] result,
	output logic                         overflow,
	output logic                         unsupported
);

	import fpStatusPkg::*;

	fpFlags outFlags;

	alignBusIf alignBus ();
	sumBusIf   sumBus ();

	operandDecode decode (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.opA     (opA),
		.opB     (opB),
		.align   (alignBus)
	);

	alignExecute execute (
		.clk   (clk),
		.rstN  (rstN),
		.align (alignBus),
		.sum   (sumBus)
	);

	resultPack pack (
		.clk      (clk),
		.rstN     (rstN),
		.sum      (sumBus),
		.outValid (outValid),
		.result   (result),
		.flags    (outFlags)
	);

	assign overflow    = outFlags.overflow;
	assign unsupported = outFlags.unsupported;

endmodule

`default_nettype wire

// File: tb/fpAdd_assertions.sv
`timescale 1ns/100ps
`default_nettype none

// Pipeline latency, reset and flag checks on the adder top level.
module fpAddAssertions (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic outValid,
	input logic overflow,
	input logic unsupported
);

	int failCount = 0; // Read by the testbench at the end of the run.

	// Three register stages from inValid to outValid.
	latencyCheck: assert property (@(posedge clk) disable iff (!rstN)
		outValid == $past(inValid, 3))
	else begin
		$error("outValid does not follow inValid by three cycles");
		failCount++;
	end

	resetCheck: assert property (@(posedge clk) !rstN |-> !outValid)
	else begin
		$error("outValid high during reset");
		failCount++;
	end

	flagCheck: assert property (@(posedge clk) disable iff (!rstN)
		!(overflow && unsupported))
	else begin
		$error("overflow and unsupported both set");
		failCount++;
	end

endmodule

bind fpAddTop fpAddAssertions checks (
	.clk         (clk),
	.rstN        (rstN),
	.inValid     (inValid),
	.outValid    (outValid),
	.overflow    (overflow),
	.unsupported (unsupported)
);

`default_nettype wire

// File: tb/fpAddTb.sv
`timescale 1ns/100ps
`default_nettype none

module fpAddTb;

	import fpFormatPkg::*;

	localparam int TABLE_ROWS     = 17;
	localparam int RAND_ROWS      = 20;
	localparam int TOTAL_ROWS     = TABLE_ROWS + RAND_ROWS;
	localparam int RESET_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_ROWS + 3 + 10;
	localparam int SEED           = 32'ha640;

	typedef struct packed {
		logic [FP_W-1:0] opA;
		logic [FP_W-1:0] opB;
		logic [FP_W-1:0] result;
		logic            overflow;
		logic            unsupported;
	} testRow;

	logic            clk;
	logic            rstN;
	logic            inValid;
	logic [FP_W-1:0] opA;
	logic [FP_W-1:0] opB;
	logic            outValid;
	logic [FP_W-1:0] result;
	logic            overflow;
	logic            unsupported;

	testRow vectors [TABLE_ROWS];
	testRow pending [$]; // Issued, not yet seen at the output.
	integer seed;
	int     done = 0;
	int     passed = 0;
	int     errors = 0;
	int     cycles = 0;

	fpAddTop dut (
		.clk         (clk),
		.rstN        (rstN),
		.inValid     (inValid),
		.opA         (opA),
		.opB         (opB),
		.outValid    (outValid),
		.result      (result),
		.overflow    (overflow),
		.unsupported (unsupported)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Hand-worked rows: opA, opB, result, overflow, unsupported.
	task automatic loadVectors();
		vectors[0]  = '{64'h3FF8000000000000, 64'h3FF8000000000000, 64'h4008000000000000, 1'b0, 1'b0};
		vectors[1]  = '{64'h3FF0000000000000, 64'h3C30000000000000, 64'h3FF0000000000000, 1'b0, 1'b0};
		vectors[2]  = '{64'h3FF0000000000000, 64'h3FE0000000000001, 64'h3FF8000000000000, 1'b0, 1'b0};
		vectors[3]  = '{64'h3FF0000000000000, 64'h4000000000000000, 64'h4008000000000000, 1'b0, 1'b0};
		vectors[4]  = '{64'h3FF0000000000000, 64'h3FFFFFFFFFFFFFFF, 64'h4007FFFFFFFFFFFF, 1'b0, 1'b0};
		vectors[5]  = '{64'h4004000000000000, 64'h0000000000000000, 64'h4004000000000000, 1'b0, 1'b0};
		vectors[6]  = '{64'h4004000000000000, 64'h0000000000000001, 64'h4004000000000000, 1'b0, 1'b0};
		vectors[7]  = '{64'h0000000000000000, 64'h0000000000000000, 64'h0000000000000000, 1'b0, 1'b0};
		vectors[8]  = '{64'h8000000000000000, 64'h8000000000000000, 64'h8000000000000000, 1'b0, 1'b0};
		vectors[9]  = '{64'hBFF8000000000000, 64'hBFF8000000000000, 64'hC008000000000000, 1'b0, 1'b0};
		vectors[10] = '{64'h7FE0000000000000, 64'h7FD0000000000000, 64'h7FE8000000000000, 1'b0, 1'b0};
		vectors[11] = '{64'h7FEFFFFFFFFFFFFF, 64'h7FEFFFFFFFFFFFFF, 64'h7FF0000000000000, 1'b1, 1'b0};
		vectors[12] = '{64'hFFEFFFFFFFFFFFFF, 64'hFFEFFFFFFFFFFFFF, 64'hFFF0000000000000, 1'b1, 1'b0};
		vectors[13] = '{64'h3FF0000000000000, 64'hBFF0000000000000, 64'h0000000000000000, 1'b0, 1'b1};
		vectors[14] = '{64'hC000000000000000, 64'h3FF0000000000000, 64'h8000000000000000, 1'b0, 1'b1};
		vectors[15] = '{64'h7FF0000000000000, 64'h3FF0000000000000, 64'h0000000000000000, 1'b0, 1'b1};
		vectors[16] = '{64'h3FF0000000000000, 64'h7FF8000000000000, 64'h0000000000000000, 1'b0, 1'b1};
	endtask

	// Exponents 980 to 999 keep the shifts small enough to truncate real bits.
	function automatic logic [FP_W-1:0] randomOperand(input logic sign);
		logic [EXP_W-1:0]  exponent;
		logic [FRAC_W-1:0] fraction;
		exponent = EXP_W'(980 + ($unsigned($random(seed)) % 20));
		fraction = {20'($random(seed)), $random(seed)};
		return {sign, exponent, fraction};
	endfunction

	// Align with truncation, add, normalize once.
	function automatic testRow expectedRow(input logic [FP_W-1:0] a, input logic [FP_W-1:0] b);
		testRow           row;
		logic [EXP_W-1:0] expA;
		logic [EXP_W-1:0] expB;
		logic [EXP_W-1:0] resExp;
		logic [SIG_W-1:0] sigA;
		logic [SIG_W-1:0] sigB;
		logic [SIG_W-1:0] smallSig;
		logic [SIG_W:0]   total;
		int               diff;
		expA = a[FP_W-2 -: EXP_W];
		expB = b[FP_W-2 -: EXP_W];
		sigA = (expA == '0) ? '0 : {1'b1, a[FRAC_W-1:0]};
		sigB = (expB == '0) ? '0 : {1'b1, b[FRAC_W-1:0]};
		if (expA >= expB) begin
			resExp = expA;
			diff = int'(expA) - int'(expB);
			smallSig = sigB;
			total = {1'b0, sigA};
		end else begin
			resExp = expB;
			diff = int'(expB) - int'(expA);
			smallSig = sigA;
			total = {1'b0, sigB};
		end
		if (diff < SIG_W)
			total = total + {1'b0, smallSig >> diff};
		if (total[SIG_W]) begin
			total = total >> 1;
			resExp = resExp + 1'b1;
		end
		row.opA = a;
		row.opB = b;
		row.unsupported = 1'b0;
		row.overflow = (total != '0) && (resExp == EXP_MAX);
		if (total == '0)
			row.result = {a[FP_W-1], {(FP_W-1){1'b0}}};
		else if (row.overflow)
			row.result = {a[FP_W-1], EXP_MAX, {FRAC_W{1'b0}}};
		else
			row.result = {a[FP_W-1], resExp, total[FRAC_W-1:0]};
		return row;
	endfunction

	task automatic issue(input testRow row);
		opA = row.opA;
		opB = row.opB;
		inValid = 1'b1;
		pending.push_back(row);
	endtask

	task automatic compare(input testRow want);
		int errorsBefore;
		errorsBefore = errors;
		assert (result === want.result) else begin
			$display("[ERROR] result expected %h got %h", want.result, result);
			errors++;
		end
		assert (overflow === want.overflow) else begin
			$display("[ERROR] overflow expected %h got %h", want.overflow, overflow);
			errors++;
		end
		assert (unsupported === want.unsupported) else begin
			$display("[ERROR] unsupported expected %h got %h", want.unsupported, unsupported);
			errors++;
		end
		if (errors == errorsBefore)
			passed++;
		$display("test %0d (%s) %h + %h = %h %s", done, (done < TABLE_ROWS) ? "table" : "random",
			want.opA, want.opB, result, (errors == errorsBefore) ? "ok" : "mismatch");
		done++;
	endtask

	// Outputs change on the rising edge, so they are read on the falling one.
	always @(negedge clk) begin
		if (rstN && outValid) begin
			if (pending.size() == 0) begin
				$display("Result appeared at %0t with no operation in flight", $time);
				errors++;
			end else begin
				compare(pending.pop_front());
			end
		end
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run timed out after %0d cycles, %0d of %0d results seen", cycles, done, TOTAL_ROWS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int              i;
		logic            sign;
		logic [FP_W-1:0] a;
		logic [FP_W-1:0] b;
		rstN = 1'b0;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		seed = SEED;
		loadVectors();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		for (i = 0; i < TABLE_ROWS; i++) begin
			@(negedge clk);
			issue(vectors[i]);
		end
		for (i = 0; i < RAND_ROWS; i++) begin
			@(negedge clk);
			sign = 1'($random(seed));
			a = randomOperand(sign);
			b = randomOperand(sign);
			issue(expectedRow(a, b));
		end
		@(negedge clk);
		inValid = 1'b0;
		wait (done == TOTAL_ROWS);
		repeat (2) @(posedge clk); // Let the last assertions evaluate.
		$display("%0d tests, %0d passed, %0d check errors, %0d assertion failures",
			done, passed, errors, dut.checks.failCount);
		if (errors == 0 && dut.checks.failCount == 0 && pending.size() == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hdl/fpFormatPkg.sv
hdl/fpStatusPkg.sv
hdl/alignBusIf.sv
hdl/sumBusIf.sv
hdl/rippleCarryAdder.sv
hdl/operandDecode.sv
hdl/alignExecute.sv
hdl/resultPack.sv
hdl/fpAddTop.sv
tb/fpAdd_assertions.sv
tb/fpAddTb.sv

// File: Makefile
TOOL    := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := fpAddTb
FLIST   := flist.f
OBJDIR  := obj_dir
LOG     := sim.log
RUNARGS := +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUNARGS) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
